// File: src/ahb_defines.svh
`ifndef AHB_DEFINES_SVH
`define AHB_DEFINES_SVH

// ------------------------------
// address map
// ------------------------------

// compared against haddr[31:12]
`define AHB_RAM_BASE_MATCH   20'h00000     // 4 KB RAM at 0x0000_0000
`define AHB_GPIO_BASE_MATCH  20'h1F800     // GPIO page at 0x1F80_0000

// ------------------------------
// slave sizing
// ------------------------------

`define AHB_RAM_ADDR_WIDTH   10            // 1024 words

`define AHB_N_SWITCHES       16
`define AHB_N_LEDS           16
`define AHB_HEX_WIDTH        32

// gpio register word index, haddr[11:2]
`define AHB_GPIO_REG_SW      10'd0         // offset 0x0, read only
`define AHB_GPIO_REG_LEDS    10'd1         // offset 0x4
`define AHB_GPIO_REG_HEX     10'd2         // offset 0x8

// hresp encoding
`define AHB_HRESP_OKAY       1'b0
`define AHB_HRESP_ERROR      1'b1

`endif

// File: src/ahb_pkg.sv
package ahb_pkg;

    // ------------------------------
    // bus encodings
    // ------------------------------

    typedef enum logic [1:0] {
        trans_idle   = 2'b00,
        trans_busy   = 2'b01,
        trans_nonseq = 2'b10,
        trans_seq    = 2'b11
    } htrans_e;

    // only the sizes a 32 bit bus can carry
    typedef enum logic [2:0] {
        size_byte = 3'b000,
        size_half = 3'b001,
        size_word = 3'b010
    } hsize_e;

    // address phase, 38 bits
    typedef struct packed {
        logic [31:0] haddr;
        htrans_e     htrans;
        logic        hwrite;
        hsize_e      hsize;
    } ahb_req_t;

    // per slave response, 34 bits
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_resp_t;

    // ------------------------------
    // decoder types
    // ------------------------------

    typedef enum logic [1:0] {
        sel_none    = 2'd0,   // idle or busy data phase
        sel_ram     = 2'd1,
        sel_gpio    = 2'd2,
        sel_default = 2'd3    // unmapped, error slave
    } slave_sel_e;

    typedef enum logic [1:0] {
        err_idle   = 2'd0,
        err_first  = 2'd1,    // hready low, hresp error
        err_second = 2'd2     // hready high, hresp error
    } err_state_e;

endpackage

// File: src/ahb_decoder.sv
`timescale 1ns/1ps
`include "ahb_defines.svh"

module ahb_decoder (
    input  logic                HCLK,
    input  logic                rst_n,
    input  ahb_pkg::ahb_req_t   req,
    input  logic                hready,
    output logic                sel_ram,
    output logic                sel_gpio,
    output ahb_pkg::slave_sel_e data_owner,
    output ahb_pkg::ahb_resp_t  default_resp
);

    logic                active;
    logic                unmapped;
    ahb_pkg::slave_sel_e owner_next;
    ahb_pkg::err_state_e err_state;
    ahb_pkg::err_state_e err_next;

    assign active = (req.htrans == ahb_pkg::trans_nonseq) ||
                    (req.htrans == ahb_pkg::trans_seq);

    // address phase selects
    assign sel_ram  = (req.haddr[31:12] == `AHB_RAM_BASE_MATCH);
    assign sel_gpio = (req.haddr[31:12] == `AHB_GPIO_BASE_MATCH);
    assign unmapped = active && !sel_ram && !sel_gpio;

    always_comb begin
        if (!active)
            owner_next = ahb_pkg::sel_none;
        else if (sel_ram)
            owner_next = ahb_pkg::sel_ram;
        else if (sel_gpio)
            owner_next = ahb_pkg::sel_gpio;
        else
            owner_next = ahb_pkg::sel_default;
    end

    // owner of the data phase, held while stalled
    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n)
            data_owner <= ahb_pkg::sel_none;
        else if (hready)
            data_owner <= owner_next;
    end

    // ------------------------------
    // default slave, two cycle error
    // ------------------------------

    always_comb begin
        err_next = err_state;
        case (err_state)
            ahb_pkg::err_idle:   if (hready && unmapped) err_next = ahb_pkg::err_first;
            ahb_pkg::err_first:  err_next = ahb_pkg::err_second;
            ahb_pkg::err_second: err_next = (hready && unmapped) ? ahb_pkg::err_first
                                                                 : ahb_pkg::err_idle;
            default:             err_next = ahb_pkg::err_idle;
        endcase
    end

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n)
            err_state <= ahb_pkg::err_idle;
        else
            err_state <= err_next;
    end

    assign default_resp.hrdata = 32'h0;
    assign default_resp.hready = (err_state != ahb_pkg::err_first);   // stall once
    assign default_resp.hresp  = (err_state == ahb_pkg::err_idle) ? `AHB_HRESP_OKAY
                                                                  : `AHB_HRESP_ERROR;

endmodule

// File: src/ahb_response_mux.sv
`timescale 1ns/1ps
`include "ahb_defines.svh"

module ahb_response_mux (
    input  ahb_pkg::slave_sel_e data_owner,
    input  ahb_pkg::ahb_resp_t  ram_resp,
    input  ahb_pkg::ahb_resp_t  gpio_resp,
    input  ahb_pkg::ahb_resp_t  default_resp,
    output logic [31:0]         hrdata,
    output logic                hresp
);

    // the decoder registers the owner, so this stays a plain mux
    always_comb begin
        case (data_owner)
            ahb_pkg::sel_ram: begin
                hrdata = ram_resp.hrdata;
                hresp  = ram_resp.hresp;
            end
            ahb_pkg::sel_gpio: begin
                hrdata = gpio_resp.hrdata;
                hresp  = gpio_resp.hresp;
            end
            ahb_pkg::sel_default: begin
                hrdata = default_resp.hrdata;
                hresp  = default_resp.hresp;
            end
            default: begin                  // no transfer in flight
                hrdata = 32'h0;
                hresp  = `AHB_HRESP_OKAY;
            end
        endcase
    end

endmodule

// File: src/ahb_ram_slave.sv
`timescale 1ns/1ps
`include "ahb_defines.svh"

module ahb_ram_slave #(
    parameter int addr_width = `AHB_RAM_ADDR_WIDTH
) (
    input  logic               HCLK,
    input  logic               rst_n,
    input  ahb_pkg::ahb_req_t  req,
    input  logic [31:0]        hwdata,
    input  logic               sel,
    input  logic               hready,
    output ahb_pkg::ahb_resp_t resp
);

    logic [31:0]           mem [0:(1 << addr_width) - 1];

    logic                  accept;
    logic [addr_width-1:0] rd_addr;
    logic [31:0]           rd_data;
    logic                  fwd;

    // pending write, data arrives in the next cycle
    logic                  wr_pending;
    logic [addr_width-1:0] wr_addr;
    ahb_pkg::hsize_e       wr_size;
    logic [1:0]            wr_lane;
    logic [3:0]            wr_be;

    assign accept = hready && sel &&
                    ((req.htrans == ahb_pkg::trans_nonseq) ||
                     (req.htrans == ahb_pkg::trans_seq));
    assign rd_addr = req.haddr[addr_width+1:2];

    // byte lanes, little endian
    always_comb begin
        case (wr_size)
            ahb_pkg::size_byte: wr_be = 4'b0001 << wr_lane;
            ahb_pkg::size_half: wr_be = wr_lane[1] ? 4'b1100 : 4'b0011;
            default:            wr_be = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n)
            wr_pending <= 1'b0;
        else if (hready)
            wr_pending <= accept && req.hwrite;
    end

    always_ff @(posedge HCLK) begin
        if (accept && req.hwrite) begin
            wr_addr <= rd_addr;
            wr_size <= req.hsize;
            wr_lane <= req.haddr[1:0];
        end
    end

    // ------------------------------
    // storage
    // ------------------------------

    always_ff @(posedge HCLK) begin
        if (wr_pending && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i])
                    mem[wr_addr][8*i +: 8] <= hwdata[8*i +: 8];
            end
        end
    end

    // read lands on the same edge as an older write to this word
    assign fwd = wr_pending && hready && (wr_addr == rd_addr);

    always_ff @(posedge HCLK) begin
        if (accept && !req.hwrite) begin
            for (int i = 0; i < 4; i++) begin
                rd_data[8*i +: 8] <= (fwd && wr_be[i]) ? hwdata[8*i +: 8]
                                                       : mem[rd_addr][8*i +: 8];
            end
        end
    end

    assign resp.hrdata = rd_data;
    assign resp.hready = 1'b1;              // zero wait
    assign resp.hresp  = `AHB_HRESP_OKAY;

endmodule

// File: src/ahb_gpio_slave.sv
`timescale 1ns/1ps
`include "ahb_defines.svh"

module ahb_gpio_slave (
    input  logic                        HCLK,
    input  logic                        rst_n,
    input  ahb_pkg::ahb_req_t           req,
    input  logic [31:0]                 hwdata,
    input  logic                        sel,
    input  logic                        hready,
    input  logic [`AHB_N_SWITCHES-1:0]  switches,
    output logic [`AHB_N_LEDS-1:0]      leds,
    output logic [`AHB_HEX_WIDTH-1:0]   hex,
    output ahb_pkg::ahb_resp_t          resp
);

    logic                       accept;
    logic                       wr_pending;
    logic [9:0]                 reg_index;      // data phase word offset
    logic [`AHB_N_SWITCHES-1:0] sw_meta;
    logic [`AHB_N_SWITCHES-1:0] sw_sync;
    logic [`AHB_N_LEDS-1:0]     leds_q;
    logic [`AHB_HEX_WIDTH-1:0]  hex_q;
    logic [31:0]                rd_word;

    assign accept = hready && sel &&
                    ((req.htrans == ahb_pkg::trans_nonseq) ||
                     (req.htrans == ahb_pkg::trans_seq));

    // switches come from the board, two flops
    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            sw_meta <= '0;
            sw_sync <= '0;
        end else begin
            sw_meta <= switches;
            sw_sync <= sw_meta;
        end
    end

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_pending <= 1'b0;
            reg_index  <= '0;
        end else if (hready) begin
            wr_pending <= accept && req.hwrite;
            if (accept)
                reg_index <= req.haddr[11:2];
        end
    end

    // ------------------------------
    // register file
    // ------------------------------

    always_ff @(posedge HCLK or negedge rst_n) begin
        if (!rst_n) begin
            leds_q <= '0;
            hex_q  <= '0;
        end else if (wr_pending && hready) begin
            case (reg_index)
                `AHB_GPIO_REG_LEDS: leds_q <= hwdata[`AHB_N_LEDS-1:0];
                `AHB_GPIO_REG_HEX:  hex_q  <= hwdata[`AHB_HEX_WIDTH-1:0];
                default:            ;                   // switches are read only
            endcase
        end
    end

    // read mux in the data phase, so a write just before is visible
    always_comb begin
        rd_word = 32'h0;
        case (reg_index)
            `AHB_GPIO_REG_SW:   rd_word[`AHB_N_SWITCHES-1:0] = sw_sync;
            `AHB_GPIO_REG_LEDS: rd_word[`AHB_N_LEDS-1:0]     = leds_q;
            `AHB_GPIO_REG_HEX:  rd_word[`AHB_HEX_WIDTH-1:0]  = hex_q;
            default:            rd_word = 32'h0;
        endcase
    end

    assign leds = leds_q;
    assign hex  = hex_q;

    assign resp.hrdata = rd_word;
    assign resp.hready = 1'b1;
    assign resp.hresp  = `AHB_HRESP_OKAY;

endmodule

// File: src/ahb_matrix.sv
`timescale 1ns/1ps
`include "ahb_defines.svh"

module ahb_matrix (
    input  logic                        HCLK,
    input  logic                        rst_n,
    input  ahb_pkg::ahb_req_t           req,
    input  logic [31:0]                 hwdata,
    input  logic [`AHB_N_SWITCHES-1:0]  switches,
    output ahb_pkg::ahb_resp_t          resp,
    output logic [`AHB_N_LEDS-1:0]      leds,
    output logic [`AHB_HEX_WIDTH-1:0]   hex
);

    logic                sel_ram;
    logic                sel_gpio;
    logic                hready_all;
    logic [31:0]         hrdata;
    logic                hresp;
    ahb_pkg::slave_sel_e data_owner;
    ahb_pkg::ahb_resp_t  ram_resp;
    ahb_pkg::ahb_resp_t  gpio_resp;
    ahb_pkg::ahb_resp_t  default_resp;

    ahb_decoder u_decoder (
        .HCLK         (HCLK),
        .rst_n        (rst_n),
        .req          (req),
        .hready       (hready_all),
        .sel_ram      (sel_ram),
        .sel_gpio     (sel_gpio),
        .data_owner   (data_owner),
        .default_resp (default_resp)
    );

    ahb_ram_slave #(
        .addr_width (`AHB_RAM_ADDR_WIDTH)
    ) u_ram (
        .HCLK   (HCLK),
        .rst_n  (rst_n),
        .req    (req),
        .hwdata (hwdata),
        .sel    (sel_ram),
        .hready (hready_all),
        .resp   (ram_resp)
    );

    ahb_gpio_slave u_gpio (
        .HCLK     (HCLK),
        .rst_n    (rst_n),
        .req      (req),
        .hwdata   (hwdata),
        .sel      (sel_gpio),
        .hready   (hready_all),
        .switches (switches),
        .leds     (leds),
        .hex      (hex),
        .resp     (gpio_resp)
    );

    // only the error slave ever stalls, but every slave gets a vote
    assign hready_all = ram_resp.hready & gpio_resp.hready & default_resp.hready;

    ahb_response_mux u_mux (
        .data_owner   (data_owner),
        .ram_resp     (ram_resp),
        .gpio_resp    (gpio_resp),
        .default_resp (default_resp),
        .hrdata       (hrdata),
        .hresp        (hresp)
    );

    assign resp = '{hrdata: hrdata, hready: hready_all, hresp: hresp};

endmodule

// File: verification/ahb_matrix_assertions.sv
`timescale 1ns/1ps

module ahb_matrix_assertions (
    input logic               HCLK,
    input logic               rst_n,
    input ahb_pkg::ahb_req_t  req,
    input ahb_pkg::ahb_resp_t resp
);

    // the only wait state on this bus comes from the error slave
    property stall_only_on_error;
        @(posedge HCLK) disable iff (!rst_n)
            !resp.hready |-> resp.hresp;
    endproperty

    // two cycle error, low cycle then high cycle
    property error_second_cycle;
        @(posedge HCLK) disable iff (!rst_n)
            !resp.hready |=> (resp.hready && resp.hresp);
    endproperty

    property req_held_while_stalled;
        @(posedge HCLK) disable iff (!rst_n)
            !resp.hready |=> $stable(req);
    endproperty

    a_stall_only_on_error: assert property (stall_only_on_error)
        else $error("hready low without an error response");
    a_error_second_cycle: assert property (error_second_cycle)
        else $error("error response not completed by a ready cycle with hresp error");
    a_req_held: assert property (req_held_while_stalled)
        else $error("address phase changed while hready was low");

endmodule

bind ahb_matrix ahb_matrix_assertions u_assertions (
    .HCLK  (HCLK),
    .rst_n (rst_n),
    .req   (req),
    .resp  (resp)
);

// File: verification/tb_ahb_matrix.sv
`timescale 1ns/1ps
`include "ahb_defines.svh"

module tb_ahb_matrix;

    localparam int n_transfers = 400;
    localparam int ram_words   = 16;                        // RAM traffic stays in this window
    localparam int timeout_ns  = n_transfers * 3 * 8 + 400;

    typedef struct packed {
        ahb_pkg::ahb_req_t   req;
        ahb_pkg::slave_sel_e owner;                         // expected data phase owner
    } xfer_t;

    logic                       HCLK;
    logic                       rst_n;
    ahb_pkg::ahb_req_t          req;
    logic [31:0]                hwdata;
    logic [`AHB_N_SWITCHES-1:0] switches;
    ahb_pkg::ahb_resp_t         resp;
    logic [`AHB_N_LEDS-1:0]     leds;
    logic [`AHB_HEX_WIDTH-1:0]  hex;

    // reference model
    logic [31:0]                ram_model [0:ram_words-1];
    logic [`AHB_N_LEDS-1:0]     leds_model;
    logic [`AHB_HEX_WIDTH-1:0]  hex_model;
    int                         sw_steady;                  // cycles since switches moved
    int                         n_checks;
    int                         n_errors;

    ahb_matrix u_dut (
        .HCLK     (HCLK),
        .rst_n    (rst_n),
        .req      (req),
        .hwdata   (hwdata),
        .switches (switches),
        .resp     (resp),
        .leds     (leds),
        .hex      (hex)
    );

    initial HCLK = 1'b0;
    always #4 HCLK = ~HCLK;

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // bytes lane to lane+size-1 take the new data in little endian order
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] wdata,
                                                input ahb_pkg::hsize_e size,
                                                input logic [1:0] lane);
        logic [31:0] merged;
        int          nbytes;
        int          b;
        merged = old_word;
        nbytes = 1 << int'(size);
        for (b = 0; b < 4; b++) begin
            if (b >= int'(lane) && b < int'(lane) + nbytes)
                merged[8*b +: 8] = wdata[8*b +: 8];
        end
        return merged;
    endfunction

    function automatic xfer_t pick_transfer(input int idx);
        xfer_t       t;
        int unsigned kind;
        int unsigned sz;
        logic [1:0]  lane;
        logic [3:0]  word;
        logic [9:0]  greg;
        t.req.haddr  = $urandom;
        t.req.htrans = ($urandom & 1) ? ahb_pkg::trans_seq : ahb_pkg::trans_nonseq;
        t.req.hwrite = 1'($urandom & 1);
        t.req.hsize  = ahb_pkg::size_word;
        kind = (idx >= n_transfers) ? 15 : $urandom % 16;
        if (idx < ram_words) begin                          // fill the RAM window first
            t.req.haddr  = {`AHB_RAM_BASE_MATCH, 6'b0, 4'(idx), 2'b00};
            t.req.hwrite = 1'b1;
            t.owner      = ahb_pkg::sel_ram;
        end else if (kind == 0 || kind == 15) begin
            t.req.htrans = ($urandom & 1) ? ahb_pkg::trans_busy : ahb_pkg::trans_idle;
            t.owner      = ahb_pkg::sel_none;
        end else if (kind <= 8) begin
            sz   = $urandom % 3;
            word = 4'($urandom % ram_words);
            case (sz)
                0: begin
                    t.req.hsize = ahb_pkg::size_byte;
                    lane        = 2'($urandom % 4);
                end
                1: begin
                    t.req.hsize = ahb_pkg::size_half;
                    lane        = 2'(($urandom % 2) * 2);
                end
                default: lane = 2'b00;
            endcase
            t.req.haddr = {`AHB_RAM_BASE_MATCH, 6'b0, word, lane};
            t.owner     = ahb_pkg::sel_ram;
        end else if (kind <= 12) begin
            greg        = 10'($urandom % 5);                // 3 and 4 are unused offsets
            t.req.haddr = {`AHB_GPIO_BASE_MATCH, greg, 2'b00};
            t.owner     = ahb_pkg::sel_gpio;
        end else begin
            while (t.req.haddr[31:12] == `AHB_RAM_BASE_MATCH ||
                   t.req.haddr[31:12] == `AHB_GPIO_BASE_MATCH)
                t.req.haddr = $urandom;
            t.owner = ahb_pkg::sel_default;
        end
        return t;
    endfunction

    // checks one data phase cycle at the falling edge
    task automatic score_data_phase(input xfer_t dp, input int dp_cycle,
                                    input logic [31:0] wdata);
        logic        exp_ready;
        logic        exp_resp;
        logic [3:0]  word;
        logic [9:0]  greg;
        exp_ready = !(dp.owner == ahb_pkg::sel_default && dp_cycle == 0);
        exp_resp  = (dp.owner == ahb_pkg::sel_default);
        word      = dp.req.haddr[5:2];
        greg      = dp.req.haddr[11:2];
        check_value("resp.hready", 32'(resp.hready), 32'(exp_ready));
        check_value("resp.hresp", 32'(resp.hresp), 32'(exp_resp));
        check_value("leds", 32'(leds), 32'(leds_model));
        check_value("hex", 32'(hex), 32'(hex_model));
        if (dp.owner == ahb_pkg::sel_none)
            check_value("resp.hrdata", resp.hrdata, 32'h0);
        else if (!dp.req.hwrite && dp.owner == ahb_pkg::sel_ram)
            check_value("resp.hrdata", resp.hrdata, ram_model[word]);
        else if (!dp.req.hwrite && dp.owner == ahb_pkg::sel_gpio) begin
            case (greg)
                10'd0: if (sw_steady >= 3) check_value("resp.hrdata", resp.hrdata,
                                                       32'(switches));
                10'd1: check_value("resp.hrdata", resp.hrdata, 32'(leds_model));
                10'd2: check_value("resp.hrdata", resp.hrdata, 32'(hex_model));
                default: check_value("resp.hrdata", resp.hrdata, 32'h0);
            endcase
        end
        // write completes on the coming edge
        if (resp.hready && dp.req.hwrite) begin
            if (dp.owner == ahb_pkg::sel_ram)
                ram_model[word] = merge_lanes(ram_model[word], wdata, dp.req.hsize,
                                              dp.req.haddr[1:0]);
            else if (dp.owner == ahb_pkg::sel_gpio && greg == 10'd1)
                leds_model = wdata[`AHB_N_LEDS-1:0];
            else if (dp.owner == ahb_pkg::sel_gpio && greg == 10'd2)
                hex_model = wdata[`AHB_HEX_WIDTH-1:0];
        end
    endtask

    // ------------------------------
    // master and checks
    // ------------------------------

    initial begin
        xfer_t       ap;                                    // address phase on the bus
        xfer_t       dp;
        logic [31:0] dp_wdata;
        int          dp_cycle;
        int          issued;
        logic        last_ready;
        void'($urandom(32'h24cdf1e8));
        n_checks   = 0;
        n_errors   = 0;
        rst_n      = 1'b0;
        req        = '0;
        hwdata     = 32'h0;
        switches   = `AHB_N_SWITCHES'($urandom);
        leds_model = '0;
        hex_model  = '0;
        ap         = '0;
        dp         = '0;
        dp_wdata   = 32'h0;
        dp_cycle   = 0;
        issued     = 0;
        last_ready = 1'b1;
        repeat (2) @(posedge HCLK);
        #1 rst_n = 1'b1;
        sw_steady = 0;
        @(negedge HCLK);
        check_value("resp.hready", 32'(resp.hready), 32'h1);
        check_value("resp.hresp", 32'(resp.hresp), 32'h0);
        check_value("leds", 32'(leds), 32'h0);
        check_value("hex", 32'(hex), 32'h0);
        while (issued < n_transfers + 2) begin
            @(posedge HCLK);
            #1;
            if (last_ready) begin
                dp       = ap;
                dp_cycle = 0;
                dp_wdata = $urandom;
                hwdata   = dp_wdata;
                ap       = pick_transfer(issued);
                req      = ap.req;
                issued++;
            end else
                dp_cycle++;                                 // hold req and hwdata while stalled
            if ($urandom % 16 == 0) begin
                switches  = `AHB_N_SWITCHES'($urandom);
                sw_steady = 0;
            end
            @(negedge HCLK);
            score_data_phase(dp, dp_cycle, dp_wdata);
            last_ready = resp.hready;
            sw_steady++;
        end
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+src
src/ahb_pkg.sv
src/ahb_decoder.sv
src/ahb_response_mux.sv
src/ahb_ram_slave.sv
src/ahb_gpio_slave.sv
src/ahb_matrix.sv
verification/ahb_matrix_assertions.sv
verification/tb_ahb_matrix.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ahb_matrix
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
